//--- dlx_consts.svh
`ifndef DLX_CONSTS_SVH
`define DLX_CONSTS_SVH

// Datapath sizes, fixed by the instruction set
`define DLX_DATA_W 32
`define DLX_NREGS  32
`define DLX_REG_W  5

// Instruction word field widths
`define DLX_OPC_W  6
`define DLX_IMM_W  16
`define DLX_FUNC_W 11
`define DLX_ALU_W  4

// Primary opcodes
`define DLX_OP_RTYPE 6'h00
`define DLX_OP_ADDI  6'h08
`define DLX_OP_ANDI  6'h0c
`define DLX_OP_ORI   6'h0d
`define DLX_OP_LW    6'h23
`define DLX_OP_SW    6'h2b

// ALU operations, equal to the low nibble of the R-type func field
`define DLX_ALU_ADD 4'h0
`define DLX_ALU_SUB 4'h2
`define DLX_ALU_AND 4'h4
`define DLX_ALU_OR  4'h5

`endif

//--- dlx_pkg.sv
`include "dlx_consts.svh"

package dlx_pkg;

	// R-type layout, destination in the third register field
	typedef struct packed {
		logic [`DLX_OPC_W-1:0]  opcode;
		logic [`DLX_REG_W-1:0]  rs1;
		logic [`DLX_REG_W-1:0]  rs2;
		logic [`DLX_REG_W-1:0]  rd;
		logic [`DLX_FUNC_W-1:0] func;
	} dlx_r_fmt_t;

	// I-type layout, destination in the second register field
	typedef struct packed {
		logic [`DLX_OPC_W-1:0] opcode;
		logic [`DLX_REG_W-1:0] rs1;
		logic [`DLX_REG_W-1:0] rd;
		logic [`DLX_IMM_W-1:0] imm;
	} dlx_i_fmt_t;

	// One fetched word, seen through either format
	typedef union packed {
		dlx_r_fmt_t r;
		dlx_i_fmt_t i;
	} dlx_instr_u;

	// Control word built by the decoder
	typedef struct packed {
		logic                  r_type;
		logic                  reg_wr;
		logic                  use_imm;
		logic                  mem_rd;
		logic                  mem_wr;
		logic [`DLX_ALU_W-1:0] alu_op;
	} dlx_ctrl_t;

	// Write-back request from the end of the pipeline
	typedef struct packed {
		logic                   reg_wr;
		logic                   r_type;
		logic [`DLX_REG_W-1:0]  rs2_wb;
		logic [`DLX_REG_W-1:0]  rd_wb;
		logic [`DLX_DATA_W-1:0] busW;
	} dlx_wb_t;

	// Packet handed to execute
	typedef struct packed {
		dlx_ctrl_t              ctrl;
		logic [`DLX_DATA_W-1:0] a_val;
		logic [`DLX_DATA_W-1:0] b_val;
		// Second ALU operand, b_val or the immediate
		logic [`DLX_DATA_W-1:0] opnd2;
		// Both candidate destinations travel on, r_type picks one at write-back
		logic [`DLX_REG_W-1:0]  rs2_idx;
		logic [`DLX_REG_W-1:0]  rd_idx;
	} dlx_id_ex_t;

endpackage

//--- flist.f
+incdir+.
dlx_pkg.sv
reg_file_pipe.sv
instr_decoder.sv
id_ex_latch.sv
id_stage.sv
id_stage_props.sv
tb_id_stage.sv

//--- id_ex_latch.sv
`include "dlx_consts.svh"

module id_ex_latch
	import dlx_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   if_valid,
	input  dlx_ctrl_t              ctrl,
	input  logic [`DLX_DATA_W-1:0] busA,
	input  logic [`DLX_DATA_W-1:0] busB,
	input  logic [`DLX_DATA_W-1:0] imm_ext,
	input  logic [`DLX_REG_W-1:0]  rs2_idx,
	input  logic [`DLX_REG_W-1:0]  rd_idx,
	output logic                   ex_valid,
	output dlx_id_ex_t             ex_pkt
);

	logic [`DLX_DATA_W-1:0] opnd2;
	dlx_id_ex_t             pkt_d;

	// Operand B mux ahead of execute
	assign opnd2 = ctrl.use_imm ? imm_ext : busB;

	always_comb begin
		pkt_d.ctrl    = ctrl;
		pkt_d.a_val   = busA;
		pkt_d.b_val   = busB;
		pkt_d.opnd2   = opnd2;
		pkt_d.rs2_idx = rs2_idx;
		pkt_d.rd_idx  = rd_idx;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid    <= 1'b0;
			ex_pkt.ctrl <= '0;
		end else begin
			ex_valid <= if_valid;
			if (if_valid) begin
				ex_pkt <= pkt_d;
			end else begin
				// Bubble, drop the controls so nothing downstream writes
				ex_pkt.ctrl <= '0;
			end
		end
	end

endmodule

//--- id_stage.sv
`include "dlx_consts.svh"

module id_stage
	import dlx_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       if_valid,
	input  dlx_instr_u if_instr,
	input  dlx_wb_t    wb,
	output logic       ex_valid,
	output dlx_id_ex_t ex_pkt
);

	// Decoder outputs
	logic [`DLX_REG_W-1:0]  rs1_idx;
	logic [`DLX_REG_W-1:0]  rs2_idx;
	logic [`DLX_REG_W-1:0]  rd_idx;
	logic [`DLX_DATA_W-1:0] imm_ext;
	dlx_ctrl_t              ctrl;

	// Register file read data
	logic [`DLX_DATA_W-1:0] busA;
	logic [`DLX_DATA_W-1:0] busB;

	instr_decoder i_instr_decoder (
		.instr   (if_instr),
		.rs1_idx (rs1_idx),
		.rs2_idx (rs2_idx),
		.rd_idx  (rd_idx),
		.imm_ext (imm_ext),
		.ctrl    (ctrl)
	);

	// Write port is fed from the end of the pipeline
	reg_file_pipe i_reg_file_pipe (
		.clk    (clk),
		.rst_n  (rst_n),
		.rs     (rs1_idx),
		.rs2    (rs2_idx),
		.rs2_wb (wb.rs2_wb),
		.rd_wb  (wb.rd_wb),
		.busW   (wb.busW),
		.r_type (wb.r_type),
		.reg_wr (wb.reg_wr),
		.busA   (busA),
		.busB   (busB)
	);

	id_ex_latch i_id_ex_latch (
		.clk      (clk),
		.rst_n    (rst_n),
		.if_valid (if_valid),
		.ctrl     (ctrl),
		.busA     (busA),
		.busB     (busB),
		.imm_ext  (imm_ext),
		.rs2_idx  (rs2_idx),
		.rd_idx   (rd_idx),
		.ex_valid (ex_valid),
		.ex_pkt   (ex_pkt)
	);

endmodule

//--- id_stage_props.sv
`include "dlx_consts.svh"

module id_stage_props
	import dlx_pkg::*;
(
	input logic       clk,
	input logic       rst_n,
	input logic       if_valid,
	input dlx_instr_u if_instr,
	input dlx_wb_t    wb,
	input logic       ex_valid,
	input dlx_id_ex_t ex_pkt
);

	logic [`DLX_DATA_W-1:0] shadow [0:`DLX_NREGS-1];
	logic [`DLX_REG_W-1:0]  wb_dest;
	dlx_ctrl_t              issue_ctrl;
	logic                   exp_valid;
	dlx_ctrl_t              exp_ctrl;
	logic [`DLX_DATA_W-1:0] exp_a;
	logic [`DLX_DATA_W-1:0] exp_b;
	logic [`DLX_DATA_W-1:0] exp_opnd2;
	logic [`DLX_REG_W-1:0]  exp_rs1;
	logic [`DLX_REG_W-1:0]  exp_rs2;
	logic [`DLX_REG_W-1:0]  exp_rd;
	int                     err_cnt = 0;

	// Expected control word per opcode
	function automatic dlx_ctrl_t ctrl_for(input dlx_instr_u w);
		dlx_ctrl_t c;
		c = '0;
		case (w.r.opcode)
			`DLX_OP_RTYPE: begin
				c.r_type = 1'b1;
				c.reg_wr = 1'b1;
				c.alu_op = w.r.func[3:0];
			end
			`DLX_OP_ADDI: c = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, `DLX_ALU_ADD};
			`DLX_OP_ANDI: c = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, `DLX_ALU_AND};
			`DLX_OP_ORI:  c = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0, `DLX_ALU_OR};
			`DLX_OP_LW:   c = '{1'b0, 1'b1, 1'b1, 1'b1, 1'b0, `DLX_ALU_ADD};
			`DLX_OP_SW:   c = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, `DLX_ALU_ADD};
			default:      c = '0;
		endcase
		return c;
	endfunction

	assign wb_dest    = wb.r_type ? wb.rd_wb : wb.rs2_wb;
	assign issue_ctrl = ctrl_for(if_instr);

	// Shadow register file and the expected packet one cycle ahead
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 0; k < `DLX_NREGS; k++) begin
				shadow[k] <= '0;
			end
			exp_valid <= 1'b0;
		end else begin
			if (wb.reg_wr && (wb_dest != 0)) begin
				shadow[wb_dest] <= wb.busW;
			end
			exp_valid <= if_valid;
			exp_ctrl  <= issue_ctrl;
			exp_a     <= shadow[if_instr.r.rs1];
			exp_b     <= shadow[if_instr.r.rs2];
			exp_rs1   <= if_instr.r.rs1;
			exp_rs2   <= if_instr.r.rs2;
			// R-type writes the third field, every other word the second
			exp_rd    <= issue_ctrl.r_type ? if_instr.r.rd : if_instr.i.rd;
			// Immediate words carry the sign-extended field
			exp_opnd2 <= issue_ctrl.use_imm ? 32'(signed'(if_instr.i.imm)) :
				shadow[if_instr.r.rs2];
		end
	end

	a_reset: assert property (@(posedge clk) !rst_n |=> !ex_valid)
		else begin
			err_cnt++;
			$error("FAILED %0t ex_valid exp=0 got=%b", $time, $sampled(ex_valid));
		end

	a_latency: assert property (@(posedge clk) disable iff (!rst_n) ex_valid == exp_valid)
		else begin
			err_cnt++;
			$error("FAILED %0t ex_valid exp=%b got=%b", $time, $sampled(exp_valid),
				$sampled(ex_valid));
		end

	a_a_val: assert property (@(posedge clk) disable iff (!rst_n)
		ex_valid |-> ex_pkt.a_val == exp_a)
		else begin
			err_cnt++;
			$error("FAILED %0t a_val exp=%h got=%h", $time, $sampled(exp_a),
				$sampled(ex_pkt.a_val));
		end

	a_b_val: assert property (@(posedge clk) disable iff (!rst_n)
		ex_valid |-> ex_pkt.b_val == exp_b)
		else begin
			err_cnt++;
			$error("FAILED %0t b_val exp=%h got=%h", $time, $sampled(exp_b),
				$sampled(ex_pkt.b_val));
		end

	// Register 0 reads zero no matter what was written to it
	a_reg_zero: assert property (@(posedge clk) disable iff (!rst_n)
		ex_valid && exp_rs1 == 0 |-> ex_pkt.a_val == 0)
		else begin
			err_cnt++;
			$error("FAILED %0t a_val exp=0 got=%h", $time, $sampled(ex_pkt.a_val));
		end

	a_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
		ex_valid |-> ex_pkt.ctrl == exp_ctrl)
		else begin
			err_cnt++;
			$error("FAILED %0t ctrl exp=%h got=%h", $time, $sampled(exp_ctrl),
				$sampled(ex_pkt.ctrl));
		end

	a_opnd2: assert property (@(posedge clk) disable iff (!rst_n)
		ex_valid |-> ex_pkt.opnd2 == exp_opnd2)
		else begin
			err_cnt++;
			$error("FAILED %0t opnd2 exp=%h got=%h", $time, $sampled(exp_opnd2),
				$sampled(ex_pkt.opnd2));
		end

	a_rs2_idx: assert property (@(posedge clk) disable iff (!rst_n)
		ex_valid |-> ex_pkt.rs2_idx == exp_rs2)
		else begin
			err_cnt++;
			$error("FAILED %0t rs2_idx exp=%h got=%h", $time, $sampled(exp_rs2),
				$sampled(ex_pkt.rs2_idx));
		end

	a_rd_idx: assert property (@(posedge clk) disable iff (!rst_n)
		ex_valid |-> ex_pkt.rd_idx == exp_rd)
		else begin
			err_cnt++;
			$error("FAILED %0t rd_idx exp=%h got=%h", $time, $sampled(exp_rd),
				$sampled(ex_pkt.rd_idx));
		end

	// Bubbles must never write or touch memory
	a_bubble: assert property (@(posedge clk) disable iff (!rst_n)
		!ex_valid |-> !(ex_pkt.ctrl.reg_wr || ex_pkt.ctrl.mem_rd || ex_pkt.ctrl.mem_wr))
		else begin
			err_cnt++;
			$error("FAILED %0t ctrl exp=0 got=%h", $time, $sampled(ex_pkt.ctrl));
		end

endmodule

//--- instr_decoder.sv
`include "dlx_consts.svh"

module instr_decoder
	import dlx_pkg::*;
(
	input  dlx_instr_u             instr,
	output logic [`DLX_REG_W-1:0]  rs1_idx,
	output logic [`DLX_REG_W-1:0]  rs2_idx,
	output logic [`DLX_REG_W-1:0]  rd_idx,
	output logic [`DLX_DATA_W-1:0] imm_ext,
	output dlx_ctrl_t              ctrl
);

	logic [`DLX_OPC_W-1:0] opcode;
	logic                  is_rtype;

	// Opcode sits at the same place in both views
	assign opcode   = instr.r.opcode;
	assign is_rtype = (opcode == `DLX_OP_RTYPE);

	// Source fields line up in both formats, the r view serves for reads
	assign rs1_idx = instr.r.rs1;
	assign rs2_idx = instr.r.rs2;

	// Third field for R-type, second field for I-type
	assign rd_idx = is_rtype ? instr.r.rd : instr.i.rd;

	// Immediate is always sign-extended, even for the logical ops
	assign imm_ext = {{(`DLX_DATA_W-`DLX_IMM_W){instr.i.imm[`DLX_IMM_W-1]}}, instr.i.imm};

	always_comb begin
		// Safe default, no write and no memory access
		ctrl         = '0;
		ctrl.alu_op  = `DLX_ALU_ADD;

		case (opcode)
			`DLX_OP_RTYPE: begin
				ctrl.r_type = 1'b1;
				ctrl.reg_wr = 1'b1;
				// ALU operation comes straight from the func field
				ctrl.alu_op = instr.r.func[`DLX_ALU_W-1:0];
			end

			`DLX_OP_ADDI: begin
				ctrl.reg_wr  = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.alu_op  = `DLX_ALU_ADD;
			end

			`DLX_OP_ANDI: begin
				ctrl.reg_wr  = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.alu_op  = `DLX_ALU_AND;
			end

			`DLX_OP_ORI: begin
				ctrl.reg_wr  = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.alu_op  = `DLX_ALU_OR;
			end

			// Address is base plus offset in both memory ops
			`DLX_OP_LW: begin
				ctrl.reg_wr  = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.mem_rd  = 1'b1;
				ctrl.alu_op  = `DLX_ALU_ADD;
			end

			`DLX_OP_SW: begin
				ctrl.use_imm = 1'b1;
				ctrl.mem_wr  = 1'b1;
				ctrl.alu_op  = `DLX_ALU_ADD;
			end

			// Unknown opcode behaves as a bubble
			default: begin
				ctrl.reg_wr = 1'b0;
				ctrl.mem_rd = 1'b0;
				ctrl.mem_wr = 1'b0;
			end
		endcase
	end

endmodule

//--- reg_file_pipe.sv
`include "dlx_consts.svh"

module reg_file_pipe (
	input  logic                   clk,
	input  logic                   rst_n,
	// Read addresses
	input  logic [`DLX_REG_W-1:0]  rs,
	input  logic [`DLX_REG_W-1:0]  rs2,
	// Write port
	input  logic [`DLX_REG_W-1:0]  rs2_wb,
	input  logic [`DLX_REG_W-1:0]  rd_wb,
	input  logic [`DLX_DATA_W-1:0] busW,
	// Destination select, rd_wb when set and rs2_wb otherwise
	input  logic                   r_type,
	input  logic                   reg_wr,
	// Read data
	output logic [`DLX_DATA_W-1:0] busA,
	output logic [`DLX_DATA_W-1:0] busB
);

	// Register 0 has no storage, it is hardwired to zero
	logic [`DLX_DATA_W-1:0] regs [1:`DLX_NREGS-1];

	logic [`DLX_REG_W-1:0] wr_dest;
	logic                  wr_en;

	// Destination field depends on the format of the writing instruction
	assign wr_dest = r_type ? rd_wb : rs2_wb;

	// Writes to register 0 are dropped
	assign wr_en = reg_wr && (wr_dest != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < `DLX_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_dest] <= busW;
		end
	end

	// Combinational reads, a write in this cycle is seen only after the edge
	always_comb begin
		if (rs == '0) begin
			busA = '0;
		end else begin
			busA = regs[rs];
		end
	end

	always_comb begin
		if (rs2 == '0) begin
			busB = '0;
		end else begin
			busB = regs[rs2];
		end
	end

endmodule

//--- tb_id_stage.sv
`include "dlx_consts.svh"

module tb_id_stage
	import dlx_pkg::*;
();

	logic       clk;
	logic       rst_n;
	logic       if_valid;
	dlx_instr_u if_instr;
	dlx_wb_t    wb;
	logic       ex_valid;
	dlx_id_ex_t ex_pkt;
	int         timeout_cnt = 0;

	id_stage i_id_stage (
		.clk      (clk),
		.rst_n    (rst_n),
		.if_valid (if_valid),
		.if_instr (if_instr),
		.wb       (wb),
		.ex_valid (ex_valid),
		.ex_pkt   (ex_pkt)
	);

	bind id_stage id_stage_props i_id_stage_props (
		.clk      (clk),
		.rst_n    (rst_n),
		.if_valid (if_valid),
		.if_instr (if_instr),
		.wb       (wb),
		.ex_valid (ex_valid),
		.ex_pkt   (ex_pkt)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic dlx_instr_u make_r(input logic [4:0] rs1, input logic [4:0] rs2,
		input logic [4:0] rd, input logic [10:0] func);
		dlx_instr_u w;
		w.r.opcode = `DLX_OP_RTYPE;
		w.r.rs1    = rs1;
		w.r.rs2    = rs2;
		w.r.rd     = rd;
		w.r.func   = func;
		return w;
	endfunction

	function automatic dlx_instr_u make_i(input logic [5:0] op, input logic [4:0] rs1,
		input logic [4:0] rd, input logic [15:0] imm);
		dlx_instr_u w;
		w.i.opcode = op;
		w.i.rs1    = rs1;
		w.i.rd     = rd;
		w.i.imm    = imm;
		return w;
	endfunction

	function automatic dlx_wb_t make_wb(input logic wr, input logic rt, input logic [4:0] rs2,
		input logic [4:0] rd, input logic [31:0] data);
		dlx_wb_t w;
		w.reg_wr = wr;
		w.r_type = rt;
		w.rs2_wb = rs2;
		w.rd_wb  = rd;
		w.busW   = data;
		return w;
	endfunction

	// Small index range so reads often hit recent writes
	function automatic dlx_instr_u random_instr();
		int unsigned kind;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [4:0]  rc;
		logic [15:0] imm;
		kind = $urandom_range(3, 0);
		ra   = 5'($urandom_range(7, 0));
		rb   = 5'($urandom_range(7, 0));
		rc   = 5'($urandom_range(7, 0));
		imm  = 16'($urandom);
		case (kind)
			0: return make_r(ra, rb, rc, 11'($urandom));
			1: begin
				case ($urandom_range(2, 0))
					0: return make_i(`DLX_OP_ADDI, ra, rb, imm);
					1: return make_i(`DLX_OP_ANDI, ra, rb, imm);
					default: return make_i(`DLX_OP_ORI, ra, rb, imm);
				endcase
			end
			2: return make_i(`DLX_OP_LW, ra, rb, imm);
			default: return make_i(`DLX_OP_SW, ra, rb, imm);
		endcase
	endfunction

	function automatic dlx_wb_t random_wb();
		return make_wb(1'($urandom), 1'($urandom), 5'($urandom_range(7, 0)),
			5'($urandom_range(7, 0)), $urandom);
	endfunction

	// One clock of stimulus, fetch side and write-back side together
	task automatic drive_cycle(input logic valid, input dlx_instr_u instr, input dlx_wb_t w);
		@(posedge clk);
		if_valid <= valid;
		if_instr <= instr;
		wb       <= w;
	endtask

	initial begin
		dlx_wb_t     no_wb;
		logic        saw_valid;
		logic        drained;
		int          assert_cnt;
		void'($urandom(93));
		no_wb    = '0;
		rst_n    = 1'b0;
		if_valid = 1'b0;
		if_instr = '0;
		wb       = '0;

		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		drive_cycle(1'b0, '0, no_wb);

		// Reads before any write
		drive_cycle(1'b1, make_r(5'd1, 5'd2, 5'd3, 11'h004), no_wb);
		drive_cycle(1'b1, make_i(`DLX_OP_ADDI, 5'd4, 5'd5, 16'h8001), no_wb);

		// Both destination selects, register 0 twice, then reg_wr low
		drive_cycle(1'b0, '0, make_wb(1'b1, 1'b1, 5'd7, 5'd3, 32'h1111_3333));
		drive_cycle(1'b0, '0, make_wb(1'b1, 1'b0, 5'd7, 5'd3, 32'h7777_0000));
		drive_cycle(1'b0, '0, make_wb(1'b1, 1'b1, 5'd5, 5'd0, 32'hdead_beef));
		drive_cycle(1'b0, '0, make_wb(1'b1, 1'b0, 5'd0, 5'd5, 32'hdead_beef));
		drive_cycle(1'b0, '0, make_wb(1'b0, 1'b1, 5'd5, 5'd6, 32'hbad0_0006));

		drive_cycle(1'b1, make_r(5'd3, 5'd7, 5'd1, 11'h005), no_wb);
		drive_cycle(1'b1, make_r(5'd0, 5'd6, 5'd2, 11'h002), no_wb);
		drive_cycle(1'b1, make_i(`DLX_OP_LW, 5'd7, 5'd0, 16'h0010), no_wb);
		drive_cycle(1'b1, make_i(`DLX_OP_SW, 5'd3, 5'd7, 16'hfffc), no_wb);
		// Undefined opcode decodes as a bubble
		drive_cycle(1'b1, make_i(6'h3f, 5'd3, 5'd7, 16'h1234), no_wb);
		// Same-cycle write returns the old value, the next read the new one
		drive_cycle(1'b1, make_r(5'd4, 5'd4, 5'd1, 11'h000),
			make_wb(1'b1, 1'b1, 5'd0, 5'd4, 32'h4444_4444));
		drive_cycle(1'b1, make_r(5'd4, 5'd0, 5'd1, 11'h000), no_wb);
		drive_cycle(1'b1, make_i(`DLX_OP_ORI, 5'd4, 5'd2, 16'h7fff), no_wb);
		drive_cycle(1'b0, '0, no_wb);

		// Random mix with mostly back-to-back issue and interleaved write-backs
		repeat (400) begin
			drive_cycle($urandom_range(3, 0) != 0, random_instr(), random_wb());
		end
		drive_cycle(1'b1, make_r(5'd1, 5'd2, 5'd3, 11'h000), no_wb);
		drive_cycle(1'b0, '0, no_wb);

		// Last packet must show up and leave
		saw_valid = 1'b0;
		drained   = 1'b0;
		for (int n = 0; n < 10 && !drained; n++) begin
			@(negedge clk);
			if (ex_valid) begin
				saw_valid = 1'b1;
			end else if (saw_valid) begin
				drained = 1'b1;
			end
		end
		if (!drained) begin
			timeout_cnt++;
			$display("Timeout while waiting for the last ex_valid to come and go");
		end
		repeat (2) @(posedge clk);

		assert_cnt = i_id_stage.i_id_stage_props.err_cnt;
		$display("Errors: %0d assertion failures, %0d timeouts", assert_cnt, timeout_cnt);
		if (assert_cnt + timeout_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
